//--- periph_output.sv
// Peripheral output block
// Drives the output pins from GPIO or peripheral functions per the
// select register, and muxes the read-back data for the CPU

module periph_output (
    input  logic [7:0]                       gpio_out,
    input  logic [7:0]                       gpio_sel,
    input  logic [periph_pkg::NUM_UART-1:0]  txd,
    input  logic [periph_pkg::NUM_UART-1:0]  busy,
    input  logic [7:0]                       ui_in,
    input  periph_pkg::periph_sel_t          sel,
    output logic [7:0]                       uo_out,
    output logic [31:0]                      rdata
);
    import periph_pkg::*;

    logic [7:0] func_out;

    // Peripheral function of each pin, unused pins stay low
    always_comb begin
        func_out = 8'h00;
        for (int k = 0; k < NUM_UART; k++) begin
            func_out[UART_PIN[k]] = txd[k];
        end
    end

    // Select bit set means the pin follows its GPIO bit
    assign uo_out = (gpio_sel & gpio_out) | (~gpio_sel & func_out);

    // Read-back data, no receiver so the UART data registers read as unmapped
    always_comb begin
        rdata = UNMAPPED_DATA;
        case (sel)
            REG_GPIO_OUT: rdata = {24'h0, uo_out};
            REG_GPIO_IN:  rdata = {24'h0, ui_in};
            REG_GPIO_SEL: rdata = {24'h0, gpio_sel};
            default:      rdata = UNMAPPED_DATA;
        endcase
        for (int k = 0; k < NUM_UART; k++) begin
            if (sel == UART_STATUS_REG[k]) begin
                rdata = {31'h0, busy[k]};
            end
        end
    end

endmodule

//--- periph_pkg.sv
// Peripheral block definitions
// Bus bundle, register map, UART channel table and pin assignment
// shared by the register decode, the transmitters and the output mux

package periph_pkg;

    // CPU data bus as seen by the peripheral block
    typedef struct packed {
        logic [27:0] addr;
        logic [1:0]  write_n;
        logic [1:0]  read_n;
        logic [31:0] wdata;
    } periph_bus_t;

    // Word register index inside the peripheral window
    typedef logic [3:0] periph_sel_t;

    // Register map
    localparam periph_sel_t REG_GPIO_OUT          = 4'd0;
    localparam periph_sel_t REG_GPIO_IN           = 4'd1;
    localparam periph_sel_t REG_GPIO_SEL          = 4'd3;
    localparam periph_sel_t REG_UART              = 4'd4;
    localparam periph_sel_t REG_UART_STATUS       = 4'd5;
    localparam periph_sel_t REG_DEBUG_UART        = 4'd6;
    localparam periph_sel_t REG_DEBUG_UART_STATUS = 4'd7;
    localparam periph_sel_t REG_NONE              = 4'd15;

    // Address bits 27 to 6 of the window at 0x8000000
    localparam logic [21:0] PERIPH_BASE = 22'h200000;

    // Channel 0 is the main UART, channel 1 the debug UART
    localparam int NUM_UART = 2;

    // Bit periods in clock cycles, kept short for simulation
    localparam logic [NUM_UART-1:0][15:0] UART_CLKS_PER_BIT = {16'd4, 16'd8};

    // Index of the stop bit in an 8N1 frame (start, 8 data, stop)
    localparam logic [3:0] UART_LAST_BIT = 4'd9;

    // Data and status register of each channel
    localparam periph_sel_t [NUM_UART-1:0] UART_DATA_REG = {
        REG_DEBUG_UART,
        REG_UART
    };
    localparam periph_sel_t [NUM_UART-1:0] UART_STATUS_REG = {
        REG_DEBUG_UART_STATUS,
        REG_UART_STATUS
    };

    // Output pin carrying each channel's txd
    localparam logic [NUM_UART-1:0][2:0] UART_PIN = {3'd6, 3'd0};

    // Read value for anything outside the map
    localparam logic [31:0] UNMAPPED_DATA = 32'hFFFF_FFFF;

endpackage

//--- periph_properties.sv
// Peripheral block checks
// Start strobes, idle UART line level and the pin levels with every
// pin on its peripheral function and both UARTs idle

module periph_properties (
    input logic                             clk,
    input logic                             rst_reg_n,
    input logic [periph_pkg::NUM_UART-1:0]  uart_start,
    input logic [periph_pkg::NUM_UART-1:0]  txd,
    input logic [periph_pkg::NUM_UART-1:0]  busy,
    input logic [7:0]                       gpio_sel,
    input logic [7:0]                       uo_out
);
    timeunit 1ns;
    timeprecision 1ps;
    import periph_pkg::*;

    for (genvar k = 0; k < NUM_UART; k++) begin : g_line
        // A strobe to an idle channel sends the start bit from the next edge
        a_start_frame: assert property (@(posedge clk) disable iff (!rst_reg_n)
            (uart_start[k] && !busy[k]) |=> (busy[k] && !txd[k]))
            else $error("UART channel %0d did not start a frame on its strobe", k);

        a_idle_high: assert property (@(posedge clk) disable iff (!rst_reg_n)
            !busy[k] |-> txd[k])
            else $error("txd low on idle UART channel %0d", k);
    end

    // Idle lines are high on pins 0 and 6, every other pin stays low
    a_idle_pins: assert property (@(posedge clk) disable iff (!rst_reg_n)
        (gpio_sel == 8'h00 && busy == '0) |-> (uo_out == 8'h41))
        else $error("Pins %02h with all functions selected and both UARTs idle", uo_out);

endmodule

bind periph_top periph_properties i_properties (
    .clk        (clk),
    .rst_reg_n  (rst_reg_n),
    .uart_start (uart_start),
    .txd        (txd),
    .busy       (busy),
    .gpio_sel   (gpio_sel),
    .uo_out     (uo_out)
);

//--- periph_regs.sv
// Peripheral register block
// Decodes the word registers of the peripheral window, holds the
// GPIO output and select registers and raises the UART start strobes

module periph_regs (
    input  logic                             clk,
    input  logic                             rst_reg_n,
    input  periph_pkg::periph_bus_t          bus,
    output periph_pkg::periph_sel_t          sel,
    output logic [7:0]                       gpio_out,
    output logic [7:0]                       gpio_sel,
    output logic [periph_pkg::NUM_UART-1:0]  uart_start,
    output logic [7:0]                       tx_byte
);
    import periph_pkg::*;

    logic is_write;
    logic is_read;
    logic in_window;

    // Any active strobe lane counts as an access
    assign is_write = bus.write_n != 2'b11;
    assign is_read  = bus.read_n != 2'b11;

    // Word aligned address inside the peripheral window
    assign in_window = (bus.addr[27:6] == PERIPH_BASE) && (bus.addr[1:0] == 2'b00);

    // Register index, only valid while an access is in progress
    always_comb begin
        if (in_window && (is_write || is_read)) begin
            sel = bus.addr[5:2];
        end else begin
            sel = REG_NONE;
        end
    end

    // GPIO registers, updated at the edge that ends the write cycle
    always_ff @(posedge clk) begin
        if (!rst_reg_n) begin
            gpio_out <= 8'h00;
            gpio_sel <= 8'h00;
        end else if (is_write) begin
            if (sel == REG_GPIO_OUT) begin
                gpio_out <= bus.wdata[7:0];
            end
            if (sel == REG_GPIO_SEL) begin
                gpio_sel <= bus.wdata[7:0];
            end
        end
    end

    // One strobe per UART data register write
    // The transmitter drops it if a frame is still going
    always_comb begin
        for (int k = 0; k < NUM_UART; k++) begin
            uart_start[k] = is_write && (sel == UART_DATA_REG[k]);
        end
    end

    // Both transmitters take the low byte of the write data
    assign tx_byte = bus.wdata[7:0];

endmodule

//--- periph_tb.sv
// Testbench for the peripheral block
// Replays periph_tests.txt on the CPU bus and checks read data, pin
// levels and UART frames. Operations: W write, R read, U start a frame
// on a channel, F wait until every started frame has been checked

module periph_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import periph_pkg::*;

    logic        clk = 1'b0;
    logic        rst_reg_n;
    periph_bus_t bus;
    logic [7:0]  ui_in;
    logic [7:0]  uo_out;
    logic [31:0] rdata;

    string       test_name [$];
    string       test_op [$];
    logic [31:0] test_addr [$];
    logic [31:0] test_data [$];
    logic [31:0] test_exp [$];
    int          limit_cycles;
    logic        tests_loaded;

    // Frame bookkeeping per UART channel
    int          frames_sent [2];
    int          main_done = 0;
    int          debug_done = 0;
    string       frame_name [2];
    logic [7:0]  frame_exp [2];

    periph_top i_periph_top (
        .clk       (clk),
        .rst_reg_n (rst_reg_n),
        .bus       (bus),
        .ui_in     (ui_in),
        .uo_out    (uo_out),
        .rdata     (rdata)
    );

    always #50 clk = ~clk;

    // Channel 0 is the main UART, channel 1 the debug UART
    function automatic int bit_period(input int ch);
        return (ch == 0) ? 8 : 4;
    endfunction

    function automatic logic [2:0] uart_pin(input int ch);
        return (ch == 0) ? 3'd0 : 3'd6;
    endfunction

    function automatic logic [31:0] uart_addr(input int ch);
        return (ch == 0) ? 32'h0800_0010 : 32'h0800_0018;
    endfunction

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("Errors found");
        $fatal(1);
    endtask

    task automatic check_rdata(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            fail_run($sformatf("Mismatch in test %s: expected %08h, actual %08h",
                               name, expected, actual));
        end
    endtask

    task automatic check_pins(input string name, input logic [7:0] expected,
                              input logic [7:0] actual);
        if (actual !== expected) begin
            fail_run($sformatf("Mismatch in test %s: expected %02h, actual %02h",
                               name, expected, actual));
        end
    endtask

    task automatic drive_idle();
        bus.addr    = 28'h0;
        bus.write_n = 2'b11;
        bus.read_n  = 2'b11;
        bus.wdata   = 32'h0;
    endtask

    task automatic bus_write(input logic [31:0] addr, input logic [31:0] data);
        @(posedge clk);
        #10;
        bus.addr    = addr[27:0];
        bus.write_n = 2'b00;
        bus.wdata   = data;
        @(posedge clk);
        #10;
        drive_idle();
    endtask

    // Read data is combinational, sampled in the middle of the cycle
    task automatic bus_read(input logic [31:0] addr, input logic [7:0] pins_in,
                            output logic [31:0] data);
        @(posedge clk);
        #10;
        bus.addr   = addr[27:0];
        bus.read_n = 2'b00;
        ui_in      = pins_in;
        #40;
        data = rdata;
        @(posedge clk);
        #10;
        drive_idle();
    endtask

    task automatic receive_frame(input int ch);
        logic [7:0] got;
        logic [2:0] pin;
        int         period;
        period = bit_period(ch);
        pin    = uart_pin(ch);
        // Edge that takes the data register write
        @(posedge clk);
        while (bus.write_n == 2'b11) begin
            @(posedge clk);
        end
        // Middle of each bit, half a clock away from the edges
        repeat (period / 2) @(posedge clk);
        #50;
        if (uo_out[pin] !== 1'b0) begin
            fail_run($sformatf("Start bit missing on channel %0d in test %s", ch, frame_name[ch]));
        end
        for (int b = 0; b < 8; b++) begin
            repeat (period) @(posedge clk);
            #50;
            got[b] = uo_out[pin];
        end
        repeat (period) @(posedge clk);
        #50;
        if (uo_out[pin] !== 1'b1) begin
            fail_run($sformatf("Stop bit missing on channel %0d in test %s", ch, frame_name[ch]));
        end
        check_pins(frame_name[ch], frame_exp[ch], got);
        // Stay until the end of the stop bit, where busy falls
        repeat (period - period / 2) @(posedge clk);
    endtask

    always begin
        wait (frames_sent[0] != main_done);
        receive_frame(0);
        main_done++;
    end

    always begin
        wait (frames_sent[1] != debug_done);
        receive_frame(1);
        debug_done++;
    end

    task automatic start_frame(input int i);
        int ch;
        ch = int'(test_addr[i]);
        if ((ch == 0 && frames_sent[0] != main_done) || (ch == 1 && frames_sent[1] != debug_done)) begin
            fail_run($sformatf("Test %s starts a frame while channel %0d is still busy",
                               test_name[i], ch));
        end
        frame_name[ch] = test_name[i];
        frame_exp[ch]  = test_exp[i][7:0];
        frames_sent[ch]++;
        bus_write(uart_addr(ch), test_data[i]);
    endtask

    task automatic load_tests();
        int          fd;
        int          count;
        string       line;
        string       name;
        string       op;
        logic [31:0] addr;
        logic [31:0] data;
        logic [31:0] exp_val;
        fd = $fopen("periph_tests.txt", "r");
        if (fd == 0) begin
            fail_run("Cannot open the test file periph_tests.txt");
        end
        limit_cycles = 40;
        while ($fgets(line, fd) != 0) begin
            if (line.len() < 2 || line.substr(0, 0) == "#") begin
                continue;
            end
            count = $sscanf(line, "%s %s %h %h %h", name, op, addr, data, exp_val);
            if (count != 5) begin
                fail_run($sformatf("Malformed line in the test file: %s", line));
            end
            test_name.push_back(name);
            test_op.push_back(op);
            test_addr.push_back(addr);
            test_data.push_back(data);
            test_exp.push_back(exp_val);
            if (op == "U") begin
                limit_cycles += 2 + 10 * bit_period(int'(addr));
            end else if (op != "F") begin
                limit_cycles += 2;
            end
        end
        $fclose(fd);
    endtask

    task automatic run_test(input int i);
        logic [31:0] data;
        if (test_op[i] == "W") begin
            bus_write(test_addr[i], test_data[i]);
            check_pins(test_name[i], test_exp[i][7:0], uo_out);
        end else if (test_op[i] == "R") begin
            bus_read(test_addr[i], test_data[i][7:0], data);
            check_rdata(test_name[i], test_exp[i], data);
        end else if (test_op[i] == "U") begin
            start_frame(i);
        end else if (test_op[i] == "F") begin
            wait (frames_sent[0] == main_done && frames_sent[1] == debug_done);
        end else begin
            fail_run($sformatf("Unknown operation %s in test %s", test_op[i], test_name[i]));
        end
    endtask

    initial begin
        wait (tests_loaded);
        repeat (limit_cycles) @(posedge clk);
        fail_run($sformatf("Timeout, the tests did not finish within %0d cycles", limit_cycles));
    end

    initial begin
        rst_reg_n      = 1'b0;
        ui_in          = 8'h00;
        frames_sent[0] = 0;
        frames_sent[1] = 0;
        tests_loaded   = 1'b0;
        drive_idle();
        load_tests();
        tests_loaded = 1'b1;
        repeat (5) @(posedge clk);
        #10;
        rst_reg_n = 1'b1;
        for (int i = 0; i < test_name.size(); i++) begin
            run_test(i);
        end
        $display("No errors");
        $finish;
    end

endmodule

//--- periph_tests.txt
# name op addr_or_channel data expected (hex)
# W: expected pins after the write, R: data drives ui_in, U: data byte, F: wait for frames
gpio_out_rst R 8000000 00 00000041
gpio_sel_rst R 800000C 00 00000000
uart_stat_rst R 8000014 00 00000000
dbg_stat_rst R 800001C 00 00000000
gpio_out_wr W 8000000 A5 41
gpio_sel_all W 800000C FF A5
gpio_out_rd R 8000000 00 000000A5
gpio_sel_rd R 800000C 00 000000FF
gpio_sel_part W 800000C 0F 45
gpio_out_mix R 8000000 00 00000045
gpio_in_rd R 8000004 3C 0000003C
unmapped_idx2 R 8000008 00 FFFFFFFF
unmapped_idx15 R 800003C 00 FFFFFFFF
outside_window R 4000000 00 FFFFFFFF
unaligned R 8000001 00 FFFFFFFF
uart_data_rd R 8000010 00 FFFFFFFF
dbg_data_rd R 8000018 00 FFFFFFFF
gpio_sel_func W 800000C 00 41
uart_frame U 0 A5 A5
uart_busy R 8000014 00 00000001
uart_second_wr W 8000010 3C 40
uart_wait F 0 0 0
uart_idle R 8000014 00 00000000
dbg_frame U 1 96 96
dbg_busy R 800001C 00 00000001
dbg_wait F 0 0 0
dbg_idle R 800001C 00 00000000
both_main U 0 5A 5A
both_dbg U 1 C3 C3
both_busy R 8000014 00 00000001
both_wait F 0 0 0
both_idle_main R 8000014 00 00000000
both_idle_dbg R 800001C 00 00000000

//--- periph_top.sv
// Peripheral block top level
// Register decode, one transmitter per UART channel and the pin and
// read-back mux. All accesses complete in the cycle they are issued

module periph_top (
    input  logic                     clk,
    input  logic                     rst_reg_n,
    input  periph_pkg::periph_bus_t  bus,
    input  logic [7:0]               ui_in,
    output logic [7:0]               uo_out,
    output logic [31:0]              rdata
);
    import periph_pkg::*;

    periph_sel_t         sel;
    logic [7:0]          gpio_out;
    logic [7:0]          gpio_sel;
    logic [NUM_UART-1:0] uart_start;
    logic [7:0]          tx_byte;
    logic [NUM_UART-1:0] txd;
    logic [NUM_UART-1:0] busy;

    periph_regs i_regs (
        .clk        (clk),
        .rst_reg_n  (rst_reg_n),
        .bus        (bus),
        .sel        (sel),
        .gpio_out   (gpio_out),
        .gpio_sel   (gpio_sel),
        .uart_start (uart_start),
        .tx_byte    (tx_byte)
    );

    // Main UART on channel 0, fast debug UART on channel 1
    for (genvar k = 0; k < NUM_UART; k++) begin : g_uart
        uart_tx #(
            .CLKS_PER_BIT (UART_CLKS_PER_BIT[k])
        ) i_uart_tx (
            .clk       (clk),
            .rst_reg_n (rst_reg_n),
            .start     (uart_start[k]),
            .data      (tx_byte),
            .txd       (txd[k]),
            .busy      (busy[k])
        );
    end

    periph_output i_output (
        .gpio_out (gpio_out),
        .gpio_sel (gpio_sel),
        .txd      (txd),
        .busy     (busy),
        .ui_in    (ui_in),
        .sel      (sel),
        .uo_out   (uo_out),
        .rdata    (rdata)
    );

endmodule

//--- run_sim.sh
#!/bin/sh
# Builds the peripheral block testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module periph_tb -Mdir obj_dir -f verilog.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/Vperiph_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -qx "No errors" sim.log; then
    echo "PASS"
    exit 0
fi
echo "FAIL"
exit 1

//--- uart_tx.sv
// UART transmitter
// Sends one 8N1 frame per start strobe, LSB first, with the bit period
// given in clock cycles. Busy covers the whole frame including stop bit

module uart_tx #(
    parameter logic [15:0] CLKS_PER_BIT = 16'd8
) (
    input  logic       clk,
    input  logic       rst_reg_n,
    input  logic       start,
    input  logic [7:0] data,
    output logic       txd,
    output logic       busy
);
    import periph_pkg::*;

    logic [15:0] bit_cnt;
    logic [3:0]  bit_idx;
    logic [8:0]  shift_reg;
    logic        bit_end;

    // Last cycle of the current bit period
    assign bit_end = bit_cnt == CLKS_PER_BIT - 16'd1;

    // Frame control
    // bit_idx 0 is the start bit, 1 to 8 the data bits, 9 the stop bit
    always_ff @(posedge clk) begin
        if (!rst_reg_n) begin
            busy    <= 1'b0;
            txd     <= 1'b1;
            bit_cnt <= 16'd0;
            bit_idx <= 4'd0;
        end else if (!busy) begin
            if (start) begin
                busy    <= 1'b1;
                txd     <= 1'b0;
                bit_cnt <= 16'd0;
                bit_idx <= 4'd0;
            end
        end else if (bit_end) begin
            bit_cnt <= 16'd0;
            bit_idx <= bit_idx + 4'd1;
            if (bit_idx == UART_LAST_BIT) begin
                busy <= 1'b0;
            end else begin
                txd <= shift_reg[0];
            end
        end else begin
            bit_cnt <= bit_cnt + 16'd1;
        end
    end

    // Data bits followed by the stop bit, refilled with ones as it shifts
    always_ff @(posedge clk) begin
        if (!busy && start) begin
            shift_reg <= {1'b1, data};
        end else if (busy && bit_end && (bit_idx != UART_LAST_BIT)) begin
            shift_reg <= {1'b1, shift_reg[8:1]};
        end
    end

endmodule

//--- verilog.f
periph_pkg.sv
periph_regs.sv
uart_tx.sv
periph_output.sv
periph_top.sv
periph_properties.sv
periph_tb.sv
